// File: hdl/rv_isa_pkg.sv
// ################################################
// RISC-V ISA definitions
// Instruction word and field types together with
// the opcode and function encodings needed to
// build ADD, AND, MUL and BLTU instructions
// ################################################

package rv_isa_pkg;

  // Whole 32-bit instruction word
  typedef logic [31:0] instr_t;

  // Register file index
  typedef logic [4:0] reg_addr_t;

  // Major opcode in bits 6:0
  typedef logic [6:0] opcode_t;

  // Minor function code in bits 14:12
  typedef logic [2:0] funct3_t;

  // Upper function code in bits 31:25 of R-type formats
  typedef logic [6:0] funct7_t;

  // Register-register ALU operations, M extension included
  localparam opcode_t OPCODE_OP = 7'b0110011;

  // Conditional branches
  localparam opcode_t OPCODE_BRANCH = 7'b1100011;

  // ADD and MUL share funct3, funct7 tells them apart
  localparam funct3_t FUNCT3_ADD = 3'b000;
  localparam funct3_t FUNCT3_AND = 3'b111;
  localparam funct3_t FUNCT3_MUL = 3'b000;

  // Branch if less than, unsigned compare
  localparam funct3_t FUNCT3_BLTU = 3'b110;

  localparam funct7_t FUNCT7_ADD = 7'b0000000;
  localparam funct7_t FUNCT7_AND = 7'b0000000;
  localparam funct7_t FUNCT7_MUL = 7'b0000001;

  // Hardwired zero register, writes to it are discarded
  localparam reg_addr_t REG_X0 = 5'd0;

endpackage

// File: hdl/xsecure_pkg.sv
// ################################################
// Dummy instruction insertion definitions
// Types for the LFSRs, the configuration register,
// the seed write port and the issue port, plus
// the LFSR polynomial and default seeds
// ################################################

package xsecure_pkg;

  // One LFSR state word
  typedef logic [31:0] lfsr_t;

  // Selects which LFSR a seed write goes to
  typedef enum logic [1:0] {
    LFSR0 = 2'd0,
    LFSR1 = 2'd1,
    LFSR2 = 2'd2
  } lfsr_sel_e;

  // Frequency setting, decoded to N = 4, 8, 16, 32 or 64
  typedef logic [3:0] dummy_freq_t;

  // Dummy kind, taken straight from LFSR0 bits 1:0
  typedef enum logic [1:0] {
    DUMMY_ADD  = 2'd0,
    DUMMY_AND  = 2'd1,
    DUMMY_MUL  = 2'd2,
    DUMMY_BLTU = 2'd3
  } dummy_kind_e;

  typedef struct packed {
    logic        enable;
    dummy_freq_t freq;
  } dummy_cfg_t;

  typedef struct packed {
    logic      we;
    lfsr_sel_e sel;
    lfsr_t     value;
  } seed_wr_t;

  // Operands are only meaningful when dummy is set
  typedef struct packed {
    logic               valid;
    logic               dummy;
    rv_isa_pkg::instr_t instr;
    lfsr_t              op_a;
    lfsr_t              op_b;
  } issue_t;

  // Galois feedback mask for x^32 + x^7 + x^5 + x^3 + x^2 + x + 1
  localparam lfsr_t LFSR_TAPS = 32'h8000_0057;

  // Default seeds, all nonzero since zero is the lockup state
  localparam lfsr_t LFSR0_SEED = 32'h7A3C_91E5;
  localparam lfsr_t LFSR1_SEED = 32'h1D6B_E204;
  localparam lfsr_t LFSR2_SEED = 32'hC58F_0A73;

  // Width of the masked LFSR0 value used for the threshold draw
  localparam int THRESH_W = 6;

endpackage

// File: hdl/lfsr_bank.sv
// ################################################
// LFSR bank
// Three seedable 32-bit Galois LFSRs that step
// together on advance and fall back to their
// default seed instead of locking up at zero
// ################################################

`timescale 1ns/1ns

module lfsr_bank (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  xsecure_pkg::seed_wr_t seed_wr,
  input  logic                  advance,
  output xsecure_pkg::lfsr_t    lfsr0,
  output xsecure_pkg::lfsr_t    lfsr1,
  output xsecure_pkg::lfsr_t    lfsr2
);

  localparam int NUM_LFSR = 3;

  // One Galois step, shifting right with feedback from bit 0
  function automatic xsecure_pkg::lfsr_t lfsr_step(input xsecure_pkg::lfsr_t cur);
    xsecure_pkg::lfsr_t nxt;
    nxt = {1'b0, cur[31:1]};
    if (cur[0]) begin
      nxt = nxt ^ xsecure_pkg::LFSR_TAPS;
    end
    return nxt;
  endfunction

  function automatic xsecure_pkg::lfsr_t default_seed(input int idx);
    xsecure_pkg::lfsr_t seed;
    case (idx)
      0:       seed = xsecure_pkg::LFSR0_SEED;
      1:       seed = xsecure_pkg::LFSR1_SEED;
      default: seed = xsecure_pkg::LFSR2_SEED;
    endcase
    return seed;
  endfunction

  xsecure_pkg::lfsr_t lfsr_q [NUM_LFSR];

  for (genvar i = 0; i < NUM_LFSR; i++) begin : g_lfsr
    localparam xsecure_pkg::lfsr_t SEED = default_seed(i);

    xsecure_pkg::lfsr_t step_val;
    xsecure_pkg::lfsr_t wr_val;
    xsecure_pkg::lfsr_t adv_val;
    logic               seed_hit;

    // Seed write addressed to this LFSR
    assign seed_hit = seed_wr.we && (seed_wr.sel == xsecure_pkg::lfsr_sel_e'(i));

    // A zero seed would freeze the register, so the default is loaded instead
    assign wr_val = (seed_wr.value == '0) ? SEED : seed_wr.value;

    assign step_val = lfsr_step(lfsr_q[i]);

    // Same recovery on stepping into zero
    assign adv_val = (step_val == '0) ? SEED : step_val;

    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        lfsr_q[i] <= SEED;
      end else if (seed_hit) begin
        // Software reseed wins over a step in the same cycle
        lfsr_q[i] <= wr_val;
      end else if (advance) begin
        lfsr_q[i] <= adv_val;
      end
    end
  end

  assign lfsr0 = lfsr_q[0];
  assign lfsr1 = lfsr_q[1];
  assign lfsr2 = lfsr_q[2];

endmodule

// File: hdl/dummy_scheduler.sv
// ################################################
// Dummy scheduler
// Holds the configuration register, counts real
// instructions against a random threshold and
// opens an idle fetch slot for a dummy
// ################################################

`timescale 1ns/1ns

module dummy_scheduler (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cfg_we,
  input  xsecure_pkg::dummy_cfg_t cfg,
  input  logic                    fetch_valid,
  input  xsecure_pkg::lfsr_t      lfsr0,
  output logic                    dummy_slot
);

  localparam int CNT_W = xsecure_pkg::THRESH_W + 1;

  // Threshold minus one, as a mask on LFSR0 (N = 4 .. 64)
  function automatic logic [xsecure_pkg::THRESH_W-1:0] freq_mask(
    input xsecure_pkg::dummy_freq_t freq
  );
    logic [xsecure_pkg::THRESH_W-1:0] mask;
    if (freq[3]) begin
      mask = 6'd63;
    end else if (freq[2]) begin
      mask = 6'd31;
    end else if (freq[1]) begin
      mask = 6'd15;
    end else if (freq[0]) begin
      mask = 6'd7;
    end else begin
      mask = 6'd3;
    end
    return mask;
  endfunction

  xsecure_pkg::dummy_cfg_t cfg_q;
  logic                    enable_draw_q;
  logic                    slot_q;
  logic [CNT_W-1:0]        cnt_q;
  logic [CNT_W-1:0]        thresh_q;
  logic [CNT_W-1:0]        thresh_new;
  logic                    draw;
  logic                    pending;

  // Draw once after enabling and once in the cycle each dummy issues
  assign draw = enable_draw_q || slot_q;

  // The draw is one plus the masked LFSR0 bits, 1 to 64
  assign thresh_new = CNT_W'(lfsr0[xsecure_pkg::THRESH_W-1:0] & freq_mask(cfg_q.freq)) + 1'b1;

  assign pending = cfg_q.enable && (cnt_q >= thresh_q);

  // The stale count is still above threshold in the draw cycle,
  // hence the draw term
  assign dummy_slot = pending && !fetch_valid && !draw;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cfg_q         <= '0;
      enable_draw_q <= 1'b0;
      slot_q        <= 1'b0;
      cnt_q         <= '0;
      thresh_q      <= CNT_W'(1);
    end else begin
      if (cfg_we) begin
        cfg_q <= cfg;
      end
      enable_draw_q <= cfg_we && cfg.enable;
      slot_q        <= dummy_slot;

      if (!cfg_q.enable) begin
        cnt_q <= '0;
      end else if (draw) begin
        thresh_q <= thresh_new;
        // A fetch in the draw cycle already counts toward the new threshold
        cnt_q    <= fetch_valid ? CNT_W'(1) : '0;
      end else if (fetch_valid && !pending) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: hdl/issue_stage.sv
// ################################################
// Issue stage
// Builds a dummy ADD, AND, MUL or BLTU from LFSR0
// and registers either the fetched instruction or
// the dummy with its LFSR1/LFSR2 operands
// ################################################

`timescale 1ns/1ns

module issue_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_valid,
  input  rv_isa_pkg::instr_t    fetch_instr,
  input  logic                  dummy_slot,
  input  xsecure_pkg::lfsr_t    lfsr0,
  input  xsecure_pkg::lfsr_t    lfsr1,
  input  xsecure_pkg::lfsr_t    lfsr2,
  output xsecure_pkg::issue_t   issue
);

  xsecure_pkg::dummy_kind_e kind;
  rv_isa_pkg::reg_addr_t    rs1;
  rv_isa_pkg::reg_addr_t    rs2;
  rv_isa_pkg::opcode_t      opcode;
  rv_isa_pkg::funct3_t      funct3;
  rv_isa_pkg::funct7_t      funct7;
  rv_isa_pkg::instr_t       dummy_instr;
  xsecure_pkg::issue_t      issue_q;

  assign kind = xsecure_pkg::dummy_kind_e'(lfsr0[1:0]);
  assign rs1  = lfsr0[6:2];
  assign rs2  = lfsr0[11:7];

  always_comb begin
    opcode = rv_isa_pkg::OPCODE_OP;
    funct3 = rv_isa_pkg::FUNCT3_ADD;
    funct7 = rv_isa_pkg::FUNCT7_ADD;
    case (kind)
      xsecure_pkg::DUMMY_AND: begin
        funct3 = rv_isa_pkg::FUNCT3_AND;
        funct7 = rv_isa_pkg::FUNCT7_AND;
      end
      xsecure_pkg::DUMMY_MUL: begin
        funct3 = rv_isa_pkg::FUNCT3_MUL;
        funct7 = rv_isa_pkg::FUNCT7_MUL;
      end
      xsecure_pkg::DUMMY_BLTU: begin
        opcode = rv_isa_pkg::OPCODE_BRANCH;
        funct3 = rv_isa_pkg::FUNCT3_BLTU;
      end
      default: begin
        funct3 = rv_isa_pkg::FUNCT3_ADD;
      end
    endcase
  end

  always_comb begin
    if (opcode == rv_isa_pkg::OPCODE_BRANCH) begin
      // B-type with all immediate bits zero, the branch lands on itself
      // and the core treats it as falling through
      dummy_instr = {7'b0, rs2, rs1, funct3, 5'b0, opcode};
    end else begin
      // R-type with rd = x0 so the result is thrown away
      dummy_instr = {funct7, rs2, rs1, funct3, rv_isa_pkg::REG_X0, opcode};
    end
  end

  // Valid and dummy flags
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      issue_q.valid <= 1'b0;
      issue_q.dummy <= 1'b0;
    end else begin
      issue_q.valid <= fetch_valid || dummy_slot;
      issue_q.dummy <= dummy_slot;
    end
  end

  // A real fetch always takes the payload slot
  always_ff @(posedge clk_i) begin
    if (fetch_valid) begin
      issue_q.instr <= fetch_instr;
    end else if (dummy_slot) begin
      issue_q.instr <= dummy_instr;
      issue_q.op_a  <= lfsr1;
      issue_q.op_b  <= lfsr2;
    end
  end

  assign issue = issue_q;

endmodule

// File: hdl/dummy_inserter.sv
// ################################################
// Dummy instruction inserter
// Fetch-to-decode boundary with random dummy
// instructions placed in idle fetch slots
// ################################################

`timescale 1ns/1ns

module dummy_inserter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_valid,
  input  rv_isa_pkg::instr_t      fetch_instr,
  input  logic                    cfg_we,
  input  xsecure_pkg::dummy_cfg_t cfg,
  input  xsecure_pkg::seed_wr_t   seed_wr,
  output xsecure_pkg::issue_t     issue
);

  logic               dummy_slot;
  xsecure_pkg::lfsr_t lfsr0;
  xsecure_pkg::lfsr_t lfsr1;
  xsecure_pkg::lfsr_t lfsr2;

  // All three LFSRs step each time a dummy goes out
  lfsr_bank u_lfsr_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .seed_wr (seed_wr),
    .advance (dummy_slot),
    .lfsr0   (lfsr0),
    .lfsr1   (lfsr1),
    .lfsr2   (lfsr2)
  );

  dummy_scheduler u_dummy_scheduler (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we      (cfg_we),
    .cfg         (cfg),
    .fetch_valid (fetch_valid),
    .lfsr0       (lfsr0),
    .dummy_slot  (dummy_slot)
  );

  issue_stage u_issue_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .dummy_slot  (dummy_slot),
    .lfsr0       (lfsr0),
    .lfsr1       (lfsr1),
    .lfsr2       (lfsr2),
    .issue       (issue)
  );

endmodule

// File: dv/dummy_inserter_sva.sv
// ################################################
// Dummy inserter port assertions
// Checks dummy placement, the x0 destination of
// ALU dummies, the enable gating and the issue
// port state right after reset
// ################################################

`timescale 1ns/1ns

module dummy_inserter_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    fetch_valid,
  input logic                    cfg_we,
  input xsecure_pkg::dummy_cfg_t cfg,
  input xsecure_pkg::issue_t     issue
);

  // Shadow of the enable bit, rebuilt from the configuration writes
  logic enable_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
    end else if (cfg_we) begin
      enable_q <= cfg.enable;
    end
  end

  a_dummy_after_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue.valid && issue.dummy |-> !$past(fetch_valid))
    else $error("dummy issued although the previous cycle carried a fetch strobe");

  a_alu_dummy_rd_x0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue.valid && issue.dummy && (issue.instr[6:0] != rv_isa_pkg::OPCODE_BRANCH)
    |-> issue.instr[11:7] == rv_isa_pkg::REG_X0)
    else $error("ALU dummy writes a register other than x0");

  // The slot is decided one cycle before the dummy shows up on the port
  a_no_dummy_disabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue.valid && issue.dummy |-> $past(enable_q))
    else $error("dummy issued while the feature was disabled");

  a_idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !issue.valid)
    else $error("issue port valid in the first cycle after reset");

endmodule

// File: dv/tb_dummy_inserter.sv
// ################################################
// Dummy inserter testbench
// Random fetch stream with idle gaps, a model of
// LFSR1/LFSR2 and a monitor that checks order,
// dummy encoding, spacing and operands
// ################################################

`timescale 1ns/1ns

module tb_dummy_inserter;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    fetch_valid;
  logic                    cfg_we;
  rv_isa_pkg::instr_t      fetch_instr;
  xsecure_pkg::dummy_cfg_t cfg;
  xsecure_pkg::seed_wr_t   seed_wr;
  xsecure_pkg::issue_t     issue;

  integer             seed = 22181;
  int                 errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 dummy_cnt = 0;
  int                 real_since = 0;
  int                 bound_n = 0;
  bit                 prev_fetch = 1'b0;
  bit                 capture_next = 1'b0;
  logic [3:0]         kinds_seen = '0;
  xsecure_pkg::lfsr_t m1 = xsecure_pkg::LFSR1_SEED;
  xsecure_pkg::lfsr_t m2 = xsecure_pkg::LFSR2_SEED;
  xsecure_pkg::lfsr_t cap_a;
  xsecure_pkg::lfsr_t cap_b;
  rv_isa_pkg::instr_t exp_instr;
  rv_isa_pkg::instr_t exp_q [$];

  dummy_inserter u_dummy_inserter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .cfg_we      (cfg_we),
    .cfg         (cfg),
    .seed_wr     (seed_wr),
    .issue       (issue)
  );

  bind dummy_inserter dummy_inserter_sva u_dummy_inserter_sva (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_valid (fetch_valid),
    .cfg_we      (cfg_we),
    .cfg         (cfg),
    .issue       (issue)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Galois step with fallback to the default seed on zero
  function automatic xsecure_pkg::lfsr_t lfsr_next(input xsecure_pkg::lfsr_t cur,
                                                   input xsecure_pkg::lfsr_t dflt);
    xsecure_pkg::lfsr_t nxt;
    nxt = cur >> 1;
    if (cur[0]) nxt = nxt ^ xsecure_pkg::LFSR_TAPS;
    if (nxt == '0) nxt = dflt;
    return nxt;
  endfunction

  function automatic int freq_to_n(input xsecure_pkg::dummy_freq_t freq);
    int n;
    if (freq >= 8) n = 64;
    else if (freq >= 4) n = 32;
    else if (freq >= 2) n = 16;
    else if (freq == 1) n = 8;
    else n = 4;
    return n;
  endfunction

  // ALU dummies target x0, the BLTU dummy carries a zero offset
  function automatic bit legal_dummy(input rv_isa_pkg::instr_t instr);
    bit ok;
    case (instr[6:0])
      rv_isa_pkg::OPCODE_OP: begin
        ok = (instr[11:7] == rv_isa_pkg::REG_X0) && (
             (instr[14:12] == rv_isa_pkg::FUNCT3_ADD && instr[31:25] == rv_isa_pkg::FUNCT7_ADD) ||
             (instr[14:12] == rv_isa_pkg::FUNCT3_AND && instr[31:25] == rv_isa_pkg::FUNCT7_AND) ||
             (instr[14:12] == rv_isa_pkg::FUNCT3_MUL && instr[31:25] == rv_isa_pkg::FUNCT7_MUL));
      end
      rv_isa_pkg::OPCODE_BRANCH: begin
        ok = (instr[14:12] == rv_isa_pkg::FUNCT3_BLTU) && (instr[31:25] == '0) &&
             (instr[11:7] == '0);
      end
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic event_error(input string msg);
    $display("ERROR %0t %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(input string msg);
    $display("Timeout: %s", msg);
    $display("Simulation failed");
    $finish;
  endtask

  // The monitor samples mid-cycle where the issue register is stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (issue.valid && !issue.dummy) begin
        assert (prev_fetch) else event_error("real instruction issued without a fetch before it");
        if (exp_q.size() != 0) exp_instr = exp_q.pop_front();
        else exp_instr = 'x;
        assert (issue.instr === exp_instr) else value_error("issue.instr", issue.instr, exp_instr);
        real_since++;
      end else begin
        assert (!prev_fetch)
          else event_error("fetched instruction did not issue in the next cycle");
      end
      if (issue.valid && issue.dummy) begin
        assert (legal_dummy(issue.instr))
          else event_error($sformatf("dummy %h is not a legal ADD, AND, MUL or BLTU", issue.instr));
        assert (issue.op_a == m1) else value_error("issue.op_a", issue.op_a, m1);
        assert (issue.op_b == m2) else value_error("issue.op_b", issue.op_b, m2);
        assert (real_since >= 1 && real_since <= bound_n)
          else event_error($sformatf("%0d real instructions before dummy, allowed 1 to %0d",
                                     real_since, bound_n));
        if (issue.instr[6:0] == rv_isa_pkg::OPCODE_BRANCH) kinds_seen[3] = 1'b1;
        else if (issue.instr[14:12] == rv_isa_pkg::FUNCT3_AND) kinds_seen[1] = 1'b1;
        else if (issue.instr[31:25] == rv_isa_pkg::FUNCT7_MUL) kinds_seen[2] = 1'b1;
        else kinds_seen[0] = 1'b1;
        if (capture_next) begin
          cap_a = issue.op_a;
          cap_b = issue.op_b;
          capture_next = 1'b0;
        end
        m1 = lfsr_next(m1, xsecure_pkg::LFSR1_SEED);
        m2 = lfsr_next(m2, xsecure_pkg::LFSR2_SEED);
        real_since = 0;
        dummy_cnt++;
      end
      prev_fetch = fetch_valid;
    end
  end

  task automatic idle_cycles(input int n);
    fetch_valid <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  // One real instruction followed by one or two idle slots
  task automatic send_instr();
    rv_isa_pkg::instr_t instr;
    int                 gap;
    instr = $random(seed);
    gap = 1 + ($random(seed) & 1);
    fetch_valid <= 1'b1;
    fetch_instr <= instr;
    exp_q.push_back(instr);
    @(posedge clk_i);
    idle_cycles(gap);
  endtask

  task automatic write_cfg(input logic en, input xsecure_pkg::dummy_freq_t freq);
    idle_cycles(2);
    cfg_we     <= 1'b1;
    cfg.enable <= en;
    cfg.freq   <= freq;
    if (en) begin
      real_since = 0;
      bound_n = freq_to_n(freq);
    end
    @(posedge clk_i);
    cfg_we <= 1'b0;
  endtask

  task automatic write_seed(input xsecure_pkg::lfsr_sel_e sel, input xsecure_pkg::lfsr_t value);
    idle_cycles(2);
    if (sel == xsecure_pkg::LFSR1) m1 = (value == '0) ? xsecure_pkg::LFSR1_SEED : value;
    if (sel == xsecure_pkg::LFSR2) m2 = (value == '0) ? xsecure_pkg::LFSR2_SEED : value;
    seed_wr.we    <= 1'b1;
    seed_wr.sel   <= sel;
    seed_wr.value <= value;
    @(posedge clk_i);
    seed_wr.we <= 1'b0;
  endtask

  task automatic run_until_dummies(input int count, input int limit);
    int target;
    int sent;
    target = dummy_cnt + count;
    sent = 0;
    while (dummy_cnt < target && sent < limit) begin
      send_instr();
      sent++;
    end
    if (dummy_cnt < target) abort_run($sformatf("fewer than %0d dummies appeared", count));
  endtask

  task automatic run_until_capture(input int limit);
    int sent;
    sent = 0;
    while (capture_next && sent < limit) begin
      send_instr();
      sent++;
    end
    if (capture_next) abort_run("no dummy appeared after reseeding");
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    fetch_valid <= 1'b0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) abort_run("real instructions never reached the issue port");
    idle_cycles(2);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  initial begin
    int                      e;
    xsecure_pkg::dummy_freq_t freqs [5];
    xsecure_pkg::lfsr_t      v1;
    xsecure_pkg::lfsr_t      v2;
    freqs = '{4'd0, 4'd1, 4'd3, 4'd6, 4'd15};
    rst_ni      <= 1'b0;
    fetch_valid <= 1'b0;
    fetch_instr <= '0;
    cfg_we      <= 1'b0;
    cfg         <= '0;
    seed_wr     <= '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    e = errors;
    repeat (50) send_instr();
    drain();
    assert (dummy_cnt == 0) else value_error("dummy count", dummy_cnt, 0);
    end_test("defaults", e);

    e = errors;
    write_cfg(1'b1, 4'd0);
    repeat (100) send_instr();
    drain();
    end_test("passthrough", e);

    e = errors;
    for (int i = 0; i < 5; i++) begin
      write_cfg(1'b0, freqs[i]);
      write_cfg(1'b1, freqs[i]);
      run_until_dummies(4, 5 * freq_to_n(freqs[i]) + 10);
    end
    drain();
    end_test("frequency bound", e);

    e = errors;
    write_cfg(1'b0, 4'd0);
    kinds_seen = '0;
    write_cfg(1'b1, 4'd0);
    run_until_dummies(64, 400);
    assert (kinds_seen == 4'b1111)
      else event_error($sformatf("not every dummy kind appeared, seen mask %b", kinds_seen));
    drain();
    end_test("dummy encoding", e);

    e = errors;
    v1 = $random(seed) | 1;
    v2 = $random(seed) | 1;
    write_cfg(1'b0, 4'd0);
    write_seed(xsecure_pkg::LFSR1, v1);
    write_seed(xsecure_pkg::LFSR2, v2);
    capture_next = 1'b1;
    write_cfg(1'b1, 4'd0);
    run_until_capture(100);
    assert (cap_a == v1) else value_error("reseeded op_a", cap_a, v1);
    assert (cap_b == v2) else value_error("reseeded op_b", cap_b, v2);
    run_until_dummies(10, 100);
    drain();
    end_test("operands and reseeding", e);

    e = errors;
    write_cfg(1'b0, 4'd0);
    write_seed(xsecure_pkg::LFSR1, '0);
    capture_next = 1'b1;
    write_cfg(1'b1, 4'd0);
    run_until_capture(100);
    assert (cap_a == xsecure_pkg::LFSR1_SEED)
      else value_error("op_a after zero seed", cap_a, xsecure_pkg::LFSR1_SEED);
    write_cfg(1'b0, 4'd0);
    drain();
    end_test("lockup recovery", e);

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
hdl/rv_isa_pkg.sv
hdl/xsecure_pkg.sv
hdl/lfsr_bank.sv
hdl/dummy_scheduler.sv
hdl/issue_stage.sv
hdl/dummy_inserter.sv
dv/dummy_inserter_sva.sv
dv/tb_dummy_inserter.sv
